/* tb.f */
rtl/icache_pkg.sv
rtl/icache_array.sv
rtl/icache_refill_ctrl.sv
rtl/inst_queue.sv
rtl/icache_top.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

/* Makefile */
TOP := icache_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f $(wildcard rtl/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir

/* verif/icache_tb.sv */
`timescale 1ns/1ns

module icache_tb;
	localparam int CLK_PERIOD = 4;
	localparam int DIRECTED_FETCHES = 16;
	localparam int RANDOM_FETCHES = 300;
	// Eight locked beats plus decode stalls and a wide margin
	localparam int MISS_CYCLES = 100;
	localparam int WATCHDOG_NS =
		((DIRECTED_FETCHES + RANDOM_FETCHES) * MISS_CYCLES + 20) * CLK_PERIOD;

	logic                             iCLOCK = 1'b0;
	logic                             inRESET;
	logic                             flush;
	icache_pkg::fetch_req_t           fetch_req;
	logic                             fetch_lock;
	icache_pkg::mem_req_t             mem_req;
	logic                             mem_lock;
	icache_pkg::mem_rsp_t             mem_rsp;
	icache_pkg::inst_pair_t           out_pair;
	logic                             out_ready;
	logic [icache_pkg::HIT_CNT_W-1:0] hit_count;

	integer                 seed;
	logic                   ready_random;
	string                  test_name;
	icache_pkg::inst_pair_t expected_q [$];
	int                     predicted_hits;
	// Tag model of the direct-mapped array
	logic                   model_valid [16];
	logic [21:0]            model_tag [16];

	icache_top dut0 (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.flush     (flush),
		.fetch_req (fetch_req),
		.fetch_lock(fetch_lock),
		.mem_req   (mem_req),
		.mem_lock  (mem_lock),
		.mem_rsp   (mem_rsp),
		.out_pair  (out_pair),
		.out_ready (out_ready),
		.hit_count (hit_count)
	);

	icache_mem_model mem0 (
		.iCLOCK  (iCLOCK),
		.mem_req (mem_req),
		.mem_lock(mem_lock),
		.mem_rsp (mem_rsp)
	);

	always #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	// Expected pair from the fetch address alone
	function automatic icache_pkg::inst_pair_t expected_pair(input logic [31:0] addr);
		icache_pkg::inst_pair_t pair;
		logic [31:0]            word_addr;
		word_addr = {addr[31:2], 2'b00};
		pair.pagefault = (addr[31:28] == 4'hf);
		pair.valid0 = 1'b1;
		pair.valid1 = !addr[2] && !pair.pagefault;
		pair.inst0 = word_addr ^ 32'h5a5a_a5a5;
		pair.inst1 = (word_addr + 32'd4) ^ 32'h5a5a_a5a5;
		return pair;
	endfunction

	task automatic check_pair(input icache_pkg::inst_pair_t got);
		icache_pkg::inst_pair_t exp;
		assert (expected_q.size() != 0) else
			fail_run($sformatf("Pair delivered in %s with no fetch outstanding", test_name));
		exp = expected_q.pop_front();
		assert ({got.valid0, got.valid1, got.pagefault} ==
			{exp.valid0, exp.valid1, exp.pagefault}) else
			fail_run($sformatf("[FAIL] %s flags expected %b actual %b", test_name,
				{exp.valid0, exp.valid1, exp.pagefault},
				{got.valid0, got.valid1, got.pagefault}));
		// Instruction values only count where they are defined
		assert (exp.pagefault || got.inst0 == exp.inst0) else
			fail_run($sformatf("[FAIL] %s inst0 expected %h actual %h", test_name,
				exp.inst0, got.inst0));
		assert (!exp.valid1 || got.inst1 == exp.inst1) else
			fail_run($sformatf("[FAIL] %s inst1 expected %h actual %h", test_name,
				exp.inst1, got.inst1));
	endtask

	task automatic check_hit_count(input logic [icache_pkg::HIT_CNT_W-1:0] expected);
		assert (hit_count == expected) else
			fail_run($sformatf("[FAIL] %s hit_count expected %0d actual %0d", test_name,
				expected, hit_count));
	endtask

	task automatic update_tag_model(input logic [31:0] addr);
		logic [3:0] index;
		index = addr[9:6];
		if (model_valid[index] && model_tag[index] == addr[31:10]) begin
			predicted_hits = predicted_hits + 1;
		end else if (addr[31:28] != 4'hf) begin
			model_valid[index] = 1'b1;
			model_tag[index] = addr[31:10];
		end
	endtask

	// Holds the request until the edge that accepts it
	task automatic send_fetch(input logic [31:0] addr);
		logic accepted;
		accepted = 1'b0;
		fetch_req.valid = 1'b1;
		fetch_req.addr = addr;
		while (!accepted) begin
			@(negedge iCLOCK);
			accepted = !fetch_lock;
			if (accepted) begin
				expected_q.push_back(expected_pair(addr));
				update_tag_model(addr);
			end
			@(posedge iCLOCK);
			#1;
		end
		fetch_req.valid = 1'b0;
	endtask

	task automatic wait_drained();
		do begin
			@(posedge iCLOCK);
		end while (expected_q.size() != 0);
		#1;
	endtask

	task automatic pulse_flush();
		flush = 1'b1;
		@(posedge iCLOCK);
		#1;
		flush = 1'b0;
		for (int i = 0; i < 16; i++) begin
			model_valid[i] = 1'b0;
		end
	endtask

	task automatic random_stream();
		logic [31:0] r;
		logic [31:0] addr;
		int          i;
		test_name = "random_stream";
		ready_random = 1'b1;
		for (i = 0; i < RANDOM_FETCHES; i++) begin
			r = $random(seed);
			// Four tags per index keeps hits and misses mixed
			addr = {20'h0, r[11:2], 2'b00};
			if (r[31:27] == 5'h1f) begin
				addr[31:28] = 4'hf;
			end
			send_fetch(addr);
			if (r[26:25] == 2'b00) begin
				@(posedge iCLOCK);
				#1;
			end
		end
		wait_drained();
		ready_random = 1'b0;
		check_hit_count(predicted_hits[icache_pkg::HIT_CNT_W-1:0]);
	endtask

	// Comparator at each decode handshake
	always @(negedge iCLOCK) begin
		if (inRESET && out_pair.valid0 && out_ready) begin
			check_pair(out_pair);
		end
	end

	initial begin
		out_ready = 1'b0;
		forever begin
			@(posedge iCLOCK);
			#1;
			if (ready_random) begin
				out_ready = (($random(seed) & 3) != 0);
			end else begin
				out_ready = 1'b1;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("Watchdog expired before all fetches were delivered");
	end

	initial begin
		logic [icache_pkg::HIT_CNT_W-1:0] start;
		seed = 32'haab8_1477;
		inRESET = 1'b0;
		flush = 1'b0;
		fetch_req = '0;
		ready_random = 1'b0;
		predicted_hits = 0;
		test_name = "reset";
		for (int i = 0; i < 16; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i] = '0;
		end
		repeat (3) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;

		test_name = "cold_miss_then_hit";
		start = hit_count;
		send_fetch(32'h0000_1040);
		wait_drained();
		check_hit_count(start);
		send_fetch(32'h0000_1048);
		wait_drained();
		check_hit_count(start + 1'b1);

		// One odd word that hits and one that misses
		test_name = "odd_word_fetch";
		start = hit_count;
		send_fetch(32'h0000_104c);
		send_fetch(32'h0000_20c4);
		wait_drained();
		check_hit_count(start + 1'b1);

		// Same index 2 with tags 1 and 2
		test_name = "conflict";
		start = hit_count;
		send_fetch(32'h0000_0480);
		send_fetch(32'h0000_0880);
		send_fetch(32'h0000_0480);
		send_fetch(32'h0000_0880);
		wait_drained();
		check_hit_count(start);

		test_name = "page_fault";
		start = hit_count;
		send_fetch(32'hf000_0100);
		wait_drained();
		send_fetch(32'hf000_0100);
		wait_drained();
		check_hit_count(start);

		test_name = "flush";
		start = hit_count;
		pulse_flush();
		send_fetch(32'h0000_1040);
		wait_drained();
		check_hit_count(start);
		send_fetch(32'h0000_1040);
		wait_drained();
		check_hit_count(start + 1'b1);

		random_stream();

		// Quiet cycles let a stray pair reach the comparator
		test_name = "end_of_run";
		repeat (8) @(posedge iCLOCK);
		#1;
		if (!fetch_lock && !out_pair.valid0) begin
			$display("All tests passed");
			$finish;
		end else begin
			fail_run("DUT still busy or holding a pair at the end of the run");
		end
	end

endmodule

/* verif/icache_mem_model.sv */
`timescale 1ns/1ns

module icache_mem_model (
	input  logic                 iCLOCK,
	input  icache_pkg::mem_req_t mem_req,
	output logic                 mem_lock,
	output icache_pkg::mem_rsp_t mem_rsp
);
	integer      seed;
	logic        accepted;
	logic [31:0] accepted_addr;
	logic [1:0]  stage_valid;
	logic [31:0] stage_addr [2];

	// Word contents follow the word address
	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'h5a5a_a5a5;
	endfunction

	initial begin
		seed = 32'haab8_1477;
		mem_lock = 1'b1;
		mem_rsp = '0;
		stage_valid = '0;
		stage_addr[0] = '0;
		stage_addr[1] = '0;
		forever begin
			@(negedge iCLOCK);
			accepted = (mem_req.valid === 1'b1) && !mem_lock;
			accepted_addr = mem_req.addr;
			@(posedge iCLOCK);
			#1;
			// Two stages give the fixed response latency
			stage_valid = {stage_valid[0], accepted};
			stage_addr[1] = stage_addr[0];
			stage_addr[0] = accepted_addr;
			mem_rsp.valid = stage_valid[1];
			mem_rsp.pagefault = stage_valid[1] && (stage_addr[1][31:28] == 4'hf);
			mem_rsp.data = {word_at(stage_addr[1] + 32'd4), word_at(stage_addr[1])};
			// Locked about one cycle in four
			mem_lock = (($random(seed) & 3) == 0);
		end
	end

endmodule

/* rtl/icache_top.sv */
`timescale 1ns/1ns

module icache_top (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             flush,
	input  icache_pkg::fetch_req_t           fetch_req,
	output logic                             fetch_lock,
	output icache_pkg::mem_req_t             mem_req,
	input  logic                             mem_lock,
	input  icache_pkg::mem_rsp_t             mem_rsp,
	output icache_pkg::inst_pair_t           out_pair,
	input  logic                             out_ready,
	output logic [icache_pkg::HIT_CNT_W-1:0] hit_count
);
	// Controller to array
	logic                          lookup_valid;
	logic [31:0]                   lookup_addr;
	logic                          result_hit;
	logic [icache_pkg::LINE_W-1:0] result_line;
	logic                          write_valid;
	logic [31:0]                   write_addr;
	logic [icache_pkg::LINE_W-1:0] write_line;

	// Controller to queue
	logic                          push;
	icache_pkg::inst_pair_t        push_pair;
	logic                          queue_space_ok;

	icache_array array0 (
		.iCLOCK       (iCLOCK),
		.inRESET      (inRESET),
		.flush        (flush),
		.lookup_valid (lookup_valid),
		.lookup_addr  (lookup_addr),
		.result_hit   (result_hit),
		.result_line  (result_line),
		.write_valid  (write_valid),
		.write_addr   (write_addr),
		.write_line   (write_line)
	);

	icache_refill_ctrl ctrl0 (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.flush          (flush),
		.fetch_req      (fetch_req),
		.fetch_lock     (fetch_lock),
		.mem_req        (mem_req),
		.mem_lock       (mem_lock),
		.mem_rsp        (mem_rsp),
		.lookup_valid   (lookup_valid),
		.lookup_addr    (lookup_addr),
		.result_hit     (result_hit),
		.result_line    (result_line),
		.write_valid    (write_valid),
		.write_addr     (write_addr),
		.write_line     (write_line),
		.push           (push),
		.push_pair      (push_pair),
		.queue_space_ok (queue_space_ok),
		.hit_count      (hit_count)
	);

	inst_queue queue0 (
		.iCLOCK         (iCLOCK),
		.inRESET        (inRESET),
		.push           (push),
		.push_pair      (push_pair),
		.queue_space_ok (queue_space_ok),
		.out_pair       (out_pair),
		.out_ready      (out_ready)
	);

endmodule

/* rtl/inst_queue.sv */
`timescale 1ns/1ns

module inst_queue (
	input  logic                   iCLOCK,
	input  logic                   inRESET,
	input  logic                   push,
	input  icache_pkg::inst_pair_t push_pair,
	output logic                   queue_space_ok,
	output icache_pkg::inst_pair_t out_pair,
	input  logic                   out_ready
);
	icache_pkg::inst_pair_t        slots [icache_pkg::QUEUE_DEPTH];
	icache_pkg::inst_pair_t        head;
	logic [icache_pkg::QPTR_W-1:0] wr_ptr;
	logic [icache_pkg::QPTR_W-1:0] rd_ptr;
	logic [icache_pkg::QPTR_W:0]   count;
	logic                          not_empty;
	logic                          pop;

	assign not_empty = (count != '0);
	assign head = slots[rd_ptr];

	// Head flags only count while an entry is held
	always_comb begin
		out_pair = head;
		out_pair.valid0 = head.valid0 && not_empty;
		out_pair.valid1 = head.valid1 && not_empty;
		out_pair.pagefault = head.pagefault && not_empty;
	end

	assign pop = out_pair.valid0 && out_ready;

	// Room for two covers a hit still in flight
	assign queue_space_ok = (count <= (icache_pkg::QPTR_W+1)'(icache_pkg::QUEUE_DEPTH - 2));

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			slots[wr_ptr] <= push_pair;
		end
	end

	// Pointers wrap naturally on a power-of-two depth
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + push - pop;
		end
	end

endmodule

/* rtl/icache_refill_ctrl.sv */
`timescale 1ns/1ns

module icache_refill_ctrl (
	input  logic                             iCLOCK,
	input  logic                             inRESET,
	input  logic                             flush,
	input  icache_pkg::fetch_req_t           fetch_req,
	output logic                             fetch_lock,
	output icache_pkg::mem_req_t             mem_req,
	input  logic                             mem_lock,
	input  icache_pkg::mem_rsp_t             mem_rsp,
	output logic                             lookup_valid,
	output logic [31:0]                      lookup_addr,
	input  logic                             result_hit,
	input  logic [icache_pkg::LINE_W-1:0]    result_line,
	output logic                             write_valid,
	output logic [31:0]                      write_addr,
	output logic [icache_pkg::LINE_W-1:0]    write_line,
	output logic                             push,
	output icache_pkg::inst_pair_t           push_pair,
	input  logic                             queue_space_ok,
	output logic [icache_pkg::HIT_CNT_W-1:0] hit_count
);
	icache_pkg::refill_state_t     state;
	logic [31:0]                   req_addr;
	logic                          lookup_q;
	logic [icache_pkg::BEAT_W:0]   issued;
	logic [icache_pkg::BEAT_W:0]   received;
	logic [icache_pkg::LINE_W-1:0] line_q;
	logic                          fault_q;
	logic                          flush_pend;
	logic                          lookup_miss;
	logic                          beat_issue;
	logic                          beat_fault;
	logic                          delivering;

	// Pick the addressed pair out of a full line
	function automatic icache_pkg::inst_pair_t make_pair(
		input logic [icache_pkg::LINE_W-1:0] line,
		input logic [31:0]                   addr,
		input logic                          fault
	);
		icache_pkg::inst_pair_t pair;
		logic [63:0]            beat;
		beat = line[addr[icache_pkg::OFFSET_W-1:3] * 64 +: 64];
		pair.valid0 = 1'b1;
		pair.valid1 = !addr[2] && !fault;
		pair.pagefault = fault;
		pair.inst0 = addr[2] ? beat[63:32] : beat[31:0];
		pair.inst1 = beat[63:32];
		return pair;
	endfunction

	assign lookup_miss = lookup_q && !result_hit;
	assign delivering = (state == icache_pkg::DELIVER);

	// Fetch side
	assign fetch_lock = (state != icache_pkg::IDLE) || lookup_miss || !queue_space_ok;
	assign lookup_valid = fetch_req.valid && !fetch_lock;
	assign lookup_addr = fetch_req.addr;

	// Beat requests walk the line from offset zero
	assign mem_req.valid = (state == icache_pkg::MEMREQ);
	assign mem_req.addr = {req_addr[31:icache_pkg::OFFSET_W], issued[icache_pkg::BEAT_W-1:0], 3'b000};
	assign beat_issue = mem_req.valid && !mem_lock;
	assign beat_fault = mem_rsp.valid && mem_rsp.pagefault;

	// Queue slot was reserved when the fetch was accepted
	assign push = (lookup_q && result_hit) || delivering;
	assign push_pair = delivering ? make_pair(line_q, req_addr, fault_q)
		: make_pair(result_line, req_addr, 1'b0);

	assign write_valid = delivering && !fault_q && !flush_pend && !flush;
	assign write_addr = {req_addr[31:icache_pkg::OFFSET_W], {icache_pkg::OFFSET_W{1'b0}}};
	assign write_line = line_q;

	always_ff @(posedge iCLOCK) begin
		if (lookup_valid) begin
			req_addr <= fetch_req.addr;
		end
	end

	// Beats shift in from the top, so beat 0 ends at the bottom
	always_ff @(posedge iCLOCK) begin
		if (mem_rsp.valid) begin
			line_q <= {mem_rsp.data, line_q[icache_pkg::LINE_W-1:64]};
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= icache_pkg::IDLE;
			lookup_q <= 1'b0;
			issued <= '0;
			received <= '0;
			fault_q <= 1'b0;
			flush_pend <= 1'b0;
			hit_count <= '0;
		end else begin
			lookup_q <= lookup_valid;
			if (lookup_q && result_hit) begin
				hit_count <= hit_count + 1'b1;
			end
			if (flush && ((state != icache_pkg::IDLE) || lookup_miss)) begin
				flush_pend <= 1'b1;
			end
			if (beat_issue) begin
				issued <= issued + 1'b1;
			end
			if (mem_rsp.valid) begin
				received <= received + 1'b1;
			end
			if (beat_fault) begin
				fault_q <= 1'b1;
			end
			case (state)
				icache_pkg::IDLE: begin
					if (lookup_miss) begin
						state <= icache_pkg::MEMREQ;
					end
				end
				icache_pkg::MEMREQ: begin
					// Stop issuing on a fault or after the last beat
					if (beat_fault || (beat_issue &&
						issued == (icache_pkg::BEAT_W+1)'(icache_pkg::LINE_BEATS - 1))) begin
						state <= icache_pkg::MEMGET;
					end
				end
				icache_pkg::MEMGET: begin
					// Drain all outstanding beats, even after a fault
					if (received == issued) begin
						state <= icache_pkg::DELIVER;
					end
				end
				icache_pkg::DELIVER: begin
					state <= icache_pkg::IDLE;
					issued <= '0;
					received <= '0;
					fault_q <= 1'b0;
					flush_pend <= 1'b0;
				end
				default: begin
					state <= icache_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

/* rtl/icache_array.sv */
`timescale 1ns/1ns

module icache_array (
	input  logic                          iCLOCK,
	input  logic                          inRESET,
	input  logic                          flush,
	input  logic                          lookup_valid,
	input  logic [31:0]                   lookup_addr,
	output logic                          result_hit,
	output logic [icache_pkg::LINE_W-1:0] result_line,
	input  logic                          write_valid,
	input  logic [31:0]                   write_addr,
	input  logic [icache_pkg::LINE_W-1:0] write_line
);
	logic [icache_pkg::TAG_W-1:0]     tag_mem [icache_pkg::NUM_LINES];
	logic [icache_pkg::LINE_W-1:0]    data_mem [icache_pkg::NUM_LINES];
	logic [icache_pkg::NUM_LINES-1:0] line_valid;

	logic [icache_pkg::INDEX_W-1:0] lookup_index;
	logic [icache_pkg::INDEX_W-1:0] write_index;
	logic [icache_pkg::TAG_W-1:0]   lookup_tag_q;
	logic [icache_pkg::TAG_W-1:0]   stored_tag_q;
	logic                           stored_valid_q;
	logic                           lookup_q;

	assign lookup_index = lookup_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
	assign write_index = write_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];

	// A flush beats a write landing on the same edge
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			line_valid <= '0;
		end else if (flush) begin
			line_valid <= '0;
		end else if (write_valid) begin
			line_valid[write_index] <= 1'b1;
		end
	end

	// Tag and line storage
	always_ff @(posedge iCLOCK) begin
		if (write_valid) begin
			tag_mem[write_index] <= write_addr[31 -: icache_pkg::TAG_W];
			data_mem[write_index] <= write_line;
		end
	end

	// Registered read port control
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			lookup_q <= 1'b0;
			stored_valid_q <= 1'b0;
		end else begin
			lookup_q <= lookup_valid;
			// A flush on the lookup edge already hides the line
			stored_valid_q <= line_valid[lookup_index] && !flush;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (lookup_valid) begin
			lookup_tag_q <= lookup_addr[31 -: icache_pkg::TAG_W];
			stored_tag_q <= tag_mem[lookup_index];
			result_line <= data_mem[lookup_index];
		end
	end

	// Tag compare against the registered request
	assign result_hit = lookup_q && stored_valid_q && (stored_tag_q == lookup_tag_q);

endmodule

/* rtl/icache_pkg.sv */
package icache_pkg;

	// Cache geometry
	localparam int LINE_BEATS = 8;
	localparam int NUM_LINES = 16;
	localparam int QUEUE_DEPTH = 4;
	localparam int HIT_CNT_W = 16;

	// Derived widths
	localparam int BEAT_W = $clog2(LINE_BEATS);
	localparam int OFFSET_W = BEAT_W + 3;
	localparam int INDEX_W = $clog2(NUM_LINES);
	localparam int TAG_W = 32 - INDEX_W - OFFSET_W;
	localparam int LINE_W = LINE_BEATS * 64;
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);

	// Refill controller states
	typedef enum logic [1:0] {
		IDLE,
		MEMREQ,
		MEMGET,
		DELIVER
	} refill_state_t;

	// Fetch request from the front end
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
	} fetch_req_t;

	// One 64-bit beat request toward memory
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
	} mem_req_t;

	// Returning beat, in request order
	typedef struct packed {
		logic        valid;
		logic        pagefault;
		logic [63:0] data;
	} mem_rsp_t;

	// Instruction pair toward decode
	typedef struct packed {
		logic        valid0;
		logic        valid1;
		logic        pagefault;
		logic [31:0] inst0;
		logic [31:0] inst1;
	} inst_pair_t;

endpackage
